// File: src.f
+incdir+test
src/cl_pkg.sv
src/cl_reg_file.sv
src/cl_tick_counter.sv
src/cl_top.sv
test/tb_cl_top.sv

// File: test/tb_cl_bus.svh
`ifndef TB_CL_BUS_SVH
`define TB_CL_BUS_SVH

// ----------------------------------------
// random source
// ----------------------------------------
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // taps 16 14 13 11
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++)
  begin
    lfsr = lfsr_next(lfsr);
    r    = {r[30:0], lfsr[15]};
  end
  return r;
endfunction

// byte lanes under sel take the new data
function automatic cl_pkg::wb_data_t apply_sel(
  input cl_pkg::wb_data_t cur,
  input cl_pkg::wb_data_t wdat,
  input logic [3:0]       sel
);
  cl_pkg::wb_data_t mask;
  mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  return (wdat & mask) | (cur & ~mask);
endfunction

// ----------------------------------------
// reference model of the register window
// ----------------------------------------
function automatic cl_pkg::wb_data_t expected_read(input cl_pkg::wb_addr_t adr);
  cl_pkg::wb_data_t r;
  r = '0;                                         // unmapped reads zero
  case (adr)
    cl_pkg::reg_id0:        r = cl_pkg::cl_id0;
    cl_pkg::reg_id1:        r = cl_pkg::cl_id1;
    cl_pkg::reg_version:    r = cl_pkg::cl_version;
    cl_pkg::reg_ctrl:
    begin
      r[cl_pkg::ctrl_enable]  = sh_enable;
      r[cl_pkg::ctrl_oneshot] = sh_oneshot;       // pulse bits stay zero
    end
    cl_pkg::reg_tick_value: r[tw-1:0] = sh_tick_value;
    cl_pkg::reg_load_value: r[cw-1:0] = sh_load_value;
    cl_pkg::reg_watermark:  r[cw-1:0] = sh_watermark;
    cl_pkg::reg_count:
    begin
      r[15:0]  = sh_cnt;
      r[23:16] = sh_tick_cnt;
      r[24]    = (sh_tick_cnt >= sh_tick_value);  // tick
      r[25]    = (sh_cnt >= sh_watermark);        // ge_watermark
    end
    default: ;
  endcase
  return r;
endfunction

// ----------------------------------------
// bus tasks
// ----------------------------------------
task automatic bus_access(
  input  logic             we,
  input  cl_pkg::wb_addr_t adr,
  input  cl_pkg::wb_data_t wdat,
  input  logic [3:0]       sel,
  output cl_pkg::wb_data_t rdat
);
  int   n;
  logic acked;
  n     = 0;
  acked = 1'b0;
  rdat  = '0;
  @(negedge clk_main_a0);
  if (wb_ack)
  begin
    $display("ERROR at %0t: ack showing before offset 0x%02h was requested", $time, adr);
    errors++;
  end
  wb_cyc   = 1'b1;                                // request held until ack
  wb_stb   = 1'b1;
  wb_we    = we;
  wb_adr   = adr;
  wb_dat_w = wdat;
  wb_sel   = sel;
  while (!acked && n < 20)
  begin
    @(negedge clk_main_a0);
    n++;
    if (wb_ack)
    begin
      acked     = 1'b1;
      rdat      = wb_dat_r;                       // valid while ack is high
      ack_cycle = cycle_cnt;
    end
  end
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  wb_we  = 1'b0;
  if (!acked)
  begin
    $display("bus did not acknowledge the access to offset 0x%02h within 20 cycles", adr);
    errors++;
  end
  else if (n != 1)
  begin
    $display("ERROR at %0t: ack for offset 0x%02h came after %0d cycles instead of 1",
             $time, adr, n);
    errors++;
  end
endtask

// write and track the effect in the shadow copy
task automatic reg_write(
  input cl_pkg::wb_addr_t adr,
  input cl_pkg::wb_data_t wdat,
  input logic [3:0]       sel
);
  cl_pkg::wb_data_t unused;
  cl_pkg::wb_data_t w;
  w = apply_sel(expected_read(adr), wdat, sel);
  bus_access(1'b1, adr, wdat, sel, unused);
  case (adr)
    cl_pkg::reg_ctrl:
    begin
      sh_enable  = w[cl_pkg::ctrl_enable];
      sh_oneshot = w[cl_pkg::ctrl_oneshot];
      if (w[cl_pkg::ctrl_clear])
      begin
        sh_cnt      = '0;                         // clear wins over load
        sh_tick_cnt = '0;
      end
      else if (w[cl_pkg::ctrl_load])
      begin
        sh_cnt = sh_load_value;
      end
    end
    cl_pkg::reg_tick_value: sh_tick_value = w[tw-1:0];
    cl_pkg::reg_load_value: sh_load_value = w[cw-1:0];
    cl_pkg::reg_watermark:  sh_watermark  = w[cw-1:0];
    default: ;                                    // read only or unmapped
  endcase
endtask

task automatic read_word(input cl_pkg::wb_addr_t adr, output cl_pkg::wb_data_t rdat);
  bus_access(1'b0, adr, '0, 4'hF, rdat);
endtask

// read and hand the result to the compare process
task automatic check_read(input cl_pkg::wb_addr_t adr);
  cl_pkg::wb_data_t got;
  read_word(adr, got);
  adr_q.push_back(adr);
  exp_q.push_back(expected_read(adr));
  got_q.push_back(got);
endtask

`endif

// File: test/tb_cl_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cl_top;

  localparam int tw = cl_pkg::tick_width_default;
  localparam int cw = cl_pkg::count_width_default;

  logic             clk_main_a0;
  logic             rst_main_n;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  cl_pkg::wb_addr_t wb_adr;
  cl_pkg::wb_data_t wb_dat_w;
  logic [3:0]       wb_sel;
  logic             wb_ack;
  cl_pkg::wb_data_t wb_dat_r;

  // shadow copy of the writable registers and the counter
  logic             sh_enable;
  logic             sh_oneshot;
  logic [tw-1:0]    sh_tick_value;
  logic [tw-1:0]    sh_tick_cnt;
  logic [cw-1:0]    sh_load_value;
  logic [cw-1:0]    sh_watermark;
  logic [cw-1:0]    sh_cnt;

  logic [15:0]      lfsr;                         // random state
  int               errors;
  int               cycle_cnt;                    // rising edges since start
  int               ack_cycle;                    // cycle_cnt at the last ack
  cl_pkg::wb_addr_t adr_q[$];                     // reads waiting for compare
  cl_pkg::wb_data_t exp_q[$];
  cl_pkg::wb_data_t got_q[$];
  cl_pkg::wb_addr_t cmp_adr;
  cl_pkg::wb_data_t cmp_exp;
  cl_pkg::wb_data_t cmp_got;

  `include "tb_cl_bus.svh"

  cl_top #(
    .tick_width  (tw),
    .count_width (cw)
  ) i_dut (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_sel      (wb_sel),
    .wb_ack      (wb_ack),
    .wb_dat_r    (wb_dat_r)
  );

  always #50 clk_main_a0 = ~clk_main_a0;          // 100 ns period

  always @(posedge clk_main_a0)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // compare every queued read against the model
  always @(posedge clk_main_a0)
  begin
    while (got_q.size() > 0)
    begin
      cmp_adr = adr_q.pop_front();
      cmp_exp = exp_q.pop_front();
      cmp_got = got_q.pop_front();
      if (cmp_got != cmp_exp)
      begin
        $display("ERROR at %0t: offset 0x%02h expected %08h read %08h",
                 $time, cmp_adr, cmp_exp, cmp_got);
        errors++;
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial
  begin
    cl_pkg::wb_data_t first;
    cl_pkg::wb_data_t second;
    logic [cw-1:0]    val;
    logic [tw-1:0]    tv;
    int               start;
    int               elapsed;
    int               i;

    clk_main_a0 = 1'b0;
    rst_main_n  = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    wb_sel      = '0;
    lfsr        = 16'd90;                         // seed
    errors      = 0;
    cycle_cnt   = 0;
    ack_cycle   = 0;
    {sh_enable, sh_oneshot, sh_tick_value, sh_tick_cnt} = '0;
    {sh_load_value, sh_watermark, sh_cnt} = '0;
    repeat (4) @(negedge clk_main_a0);
    rst_main_n = 1'b1;

    // reset values of the whole map and two unmapped offsets
    for (i = 0; i < 8; i++)
    begin
      check_read(cl_pkg::wb_addr_t'(4 * i));
    end
    check_read(8'h20);
    check_read(8'hFC);

    // random values and partial writes
    for (i = 0; i < 6; i++)
    begin
      reg_write(cl_pkg::reg_tick_value, rand_bits(32), 4'(rand_bits(4)));
      check_read(cl_pkg::reg_tick_value);
      reg_write(cl_pkg::reg_load_value, rand_bits(32), 4'(rand_bits(4)));
      check_read(cl_pkg::reg_load_value);
      reg_write(cl_pkg::reg_watermark, rand_bits(32), 4'(rand_bits(4)));
      check_read(cl_pkg::reg_watermark);
    end
    reg_write(cl_pkg::reg_id0, rand_bits(32), 4'hF);  // all of these must be ignored
    reg_write(cl_pkg::reg_id1, rand_bits(32), 4'hF);
    reg_write(cl_pkg::reg_version, rand_bits(32), 4'hF);
    reg_write(cl_pkg::reg_count, rand_bits(32), 4'hF);
    reg_write(8'h20, rand_bits(32), 4'hF);
    for (i = 0; i < 9; i++)
    begin
      check_read(cl_pkg::wb_addr_t'(4 * i));
    end

    // ----------------------------------------
    // load, watermark and clear with counting off
    // ----------------------------------------
    for (i = 0; i < 4; i++)
    begin
      val = cw'(rand_bits(cw));
      reg_write(cl_pkg::reg_load_value, 32'(val), 4'hF);
      reg_write(cl_pkg::reg_ctrl, 32'd1 << cl_pkg::ctrl_load, 4'hF);
      check_read(cl_pkg::reg_count);
      check_read(cl_pkg::reg_ctrl);               // load bit reads zero
      reg_write(cl_pkg::reg_watermark, 32'(val + 1'b1), 4'hF);
      check_read(cl_pkg::reg_count);
      reg_write(cl_pkg::reg_watermark, 32'(val), 4'hF);
      check_read(cl_pkg::reg_count);
      reg_write(cl_pkg::reg_watermark, 32'(val - 1'b1), 4'hF);
      check_read(cl_pkg::reg_count);
    end
    reg_write(cl_pkg::reg_ctrl, 32'd1 << cl_pkg::ctrl_clear, 4'hF);
    check_read(cl_pkg::reg_count);
    check_read(cl_pkg::reg_ctrl);

    // ----------------------------------------
    // free running count checked against bounds
    // ----------------------------------------
    tv = tw'(rand_bits(4));
    reg_write(cl_pkg::reg_tick_value, 32'(tv), 4'hF);
    reg_write(cl_pkg::reg_ctrl, 32'd1 << cl_pkg::ctrl_enable, 4'hF);
    start = ack_cycle;
    repeat (40 + int'(rand_bits(5))) @(negedge clk_main_a0);
    reg_write(cl_pkg::reg_ctrl, 32'd0, 4'hF);
    elapsed = ack_cycle - start;                  // edges with enable high
    read_word(cl_pkg::reg_count, first);
    read_word(cl_pkg::reg_count, second);
    if (first != second)
    begin
      $display("ERROR at %0t: count moved while disabled, %08h then %08h", $time, first, second);
      errors++;
    end
    if (first[15:0] == 16'd0)
    begin
      $display("ERROR at %0t: count stayed zero after %0d cycles", $time, elapsed);
      errors++;
    end
    if (int'(first[15:0]) > elapsed / (int'(tv) + 1))
    begin
      $display("ERROR at %0t: count %0d above bound for %0d cycles, tick value %0d",
               $time, first[15:0], elapsed, tv);
      errors++;
    end
    if (first[23:16] > tv)
    begin
      $display("ERROR at %0t: tick_cnt %0d above tick value %0d", $time, first[23:16], tv);
      errors++;
    end
    reg_write(cl_pkg::reg_ctrl, 32'd1 << cl_pkg::ctrl_clear, 4'hF);
    check_read(cl_pkg::reg_count);

    // ----------------------------------------
    // oneshot saturation and then wrap without it
    // ----------------------------------------
    reg_write(cl_pkg::reg_tick_value, 32'd0, 4'hF);
    reg_write(cl_pkg::reg_load_value, 32'h0000_FFFE, 4'hF);
    reg_write(cl_pkg::reg_ctrl, 32'b1011, 4'hF);  // load, oneshot, enable
    repeat (10) @(negedge clk_main_a0);
    sh_cnt      = '1;                             // held at the top
    sh_tick_cnt = '0;                             // period zero restarts each edge
    check_read(cl_pkg::reg_count);
    reg_write(cl_pkg::reg_ctrl, 32'd0, 4'hF);
    check_read(cl_pkg::reg_count);
    reg_write(cl_pkg::reg_ctrl, 32'b1001, 4'hF);  // load, enable
    repeat (10) @(negedge clk_main_a0);
    reg_write(cl_pkg::reg_ctrl, 32'd0, 4'hF);
    read_word(cl_pkg::reg_count, first);
    if (first[15:0] >= 16'hFFFE)
    begin
      $display("ERROR at %0t: count %04h did not wrap without oneshot", $time, first[15:0]);
      errors++;
    end

    i = 0;
    while (got_q.size() > 0 && i < 10)            // let the compare process drain
    begin
      @(negedge clk_main_a0);
      i++;
    end
    if (got_q.size() > 0)
    begin
      $display("compare queue was not emptied, %0d reads left unchecked", got_q.size());
      errors++;
    end
    $display("errors: %0d", errors);
    if (errors == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/cl_top.sv
`timescale 1ns/1ns
`default_nettype none

module cl_top #(
  parameter int tick_width  = cl_pkg::tick_width_default,
  parameter int count_width = cl_pkg::count_width_default
) (
  input  wire                     clk_main_a0,
  input  wire                     rst_main_n,
  // host register window
  input  wire                     wb_cyc,
  input  wire                     wb_stb,
  input  wire                     wb_we,
  input  wire cl_pkg::wb_addr_t   wb_adr,
  input  wire cl_pkg::wb_data_t   wb_dat_w,
  input  wire [3:0]               wb_sel,
  output logic                    wb_ack,
  output cl_pkg::wb_data_t        wb_dat_r
);

  // ----------------------------------------
  // register file to counter
  // ----------------------------------------
  logic                   enable;
  logic                   oneshot;
  logic                   clear;                  // pulse
  logic                   load;                   // pulse
  logic [tick_width-1:0]  tick_value;
  logic [count_width-1:0] load_value;
  logic [count_width-1:0] watermark;
  logic                   tick;
  logic                   ge_watermark;
  logic [tick_width-1:0]  tick_cnt;
  logic [count_width-1:0] cnt;

  cl_reg_file #(
    .tick_width  (tick_width),
    .count_width (count_width)
  ) i_reg_file (
    .clk_main_a0  (clk_main_a0),
    .rst_main_n   (rst_main_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_sel       (wb_sel),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r),
    .enable       (enable),
    .oneshot      (oneshot),
    .clear        (clear),
    .load         (load),
    .tick_value   (tick_value),
    .load_value   (load_value),
    .watermark    (watermark),
    .tick         (tick),
    .ge_watermark (ge_watermark),
    .tick_cnt     (tick_cnt),
    .cnt          (cnt)
  );

  cl_tick_counter #(
    .tick_width  (tick_width),
    .count_width (count_width)
  ) i_tick_counter (
    .clk_main_a0  (clk_main_a0),
    .rst_main_n   (rst_main_n),
    .enable       (enable),
    .oneshot      (oneshot),
    .clear        (clear),
    .load         (load),
    .tick_value   (tick_value),
    .load_value   (load_value),
    .watermark    (watermark),
    .tick         (tick),
    .ge_watermark (ge_watermark),
    .tick_cnt     (tick_cnt),
    .cnt          (cnt)
  );

endmodule

`default_nettype wire

// File: src/cl_tick_counter.sv
`timescale 1ns/1ns
`default_nettype none

module cl_tick_counter #(
  parameter int tick_width  = cl_pkg::tick_width_default,
  parameter int count_width = cl_pkg::count_width_default
) (
  input  wire                     clk_main_a0,
  input  wire                     rst_main_n,
  // controls from the register file
  input  wire                     enable,
  input  wire                     oneshot,
  input  wire                     clear,         // one cycle pulse
  input  wire                     load,          // one cycle pulse
  input  wire [tick_width-1:0]    tick_value,
  input  wire [count_width-1:0]   load_value,
  input  wire [count_width-1:0]   watermark,
  // status back to the register file
  output logic                    tick,
  output logic                    ge_watermark,
  output logic [tick_width-1:0]   tick_cnt,
  output logic [count_width-1:0]  cnt
);

  localparam logic [count_width-1:0] cnt_max = '1;  // saturation point for oneshot

  logic at_max;                                   // cnt is all ones

  // ----------------------------------------
  // compares
  // ----------------------------------------
  assign tick         = (tick_cnt >= tick_value);  // prescaler period reached
  assign ge_watermark = (cnt >= watermark);
  assign at_max       = (cnt == cnt_max);

  // ----------------------------------------
  // prescaler
  // ----------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      tick_cnt <= '0;
    end
    else if (clear)
    begin
      tick_cnt <= '0;
    end
    else if (load)
    begin
      tick_cnt <= tick_cnt;                       // load only touches cnt
    end
    else if (enable)
    begin
      if (tick)
      begin
        tick_cnt <= '0;                           // restart the period
      end
      else
      begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // event counter
  // ----------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      cnt <= '0;
    end
    else if (clear)
    begin
      cnt <= '0;
    end
    else if (load)
    begin
      cnt <= load_value;
    end
    else if (enable && tick)
    begin
      if (oneshot && at_max)
      begin
        cnt <= cnt;                               // hold at the top
      end
      else
      begin
        cnt <= cnt + 1'b1;                        // wraps when oneshot is off
      end
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  // saturated count only leaves the top through clear or load
  a_oneshot_no_wrap : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n)
    (oneshot && at_max && !clear && !load) |=> (cnt != '0)
  );

endmodule

`default_nettype wire

// File: src/cl_reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module cl_reg_file #(
  parameter int tick_width  = cl_pkg::tick_width_default,
  parameter int count_width = cl_pkg::count_width_default
) (
  input  wire                     clk_main_a0,
  input  wire                     rst_main_n,
  // wishbone classic slave
  input  wire                     wb_cyc,
  input  wire                     wb_stb,
  input  wire                     wb_we,
  input  wire cl_pkg::wb_addr_t   wb_adr,
  input  wire cl_pkg::wb_data_t   wb_dat_w,
  input  wire [3:0]               wb_sel,
  output logic                    wb_ack,
  output cl_pkg::wb_data_t        wb_dat_r,
  // counter controls
  output logic                    enable,
  output logic                    oneshot,
  output logic                    clear,
  output logic                    load,
  output logic [tick_width-1:0]   tick_value,
  output logic [count_width-1:0]  load_value,
  output logic [count_width-1:0]  watermark,
  // counter status
  input  wire                     tick,
  input  wire                     ge_watermark,
  input  wire [tick_width-1:0]    tick_cnt,
  input  wire [count_width-1:0]   cnt
);

  // status word field positions
  localparam int cnt_lsb      = 0;
  localparam int tick_cnt_lsb = 16;
  localparam int tick_bit     = 24;
  localparam int ge_bit       = 25;

  cl_pkg::wb_state_t state;                       // bus fsm
  logic              req;                         // request sampled at this edge
  logic              wr_req;                      // sampled write
  cl_pkg::wb_data_t  ctrl_word;                   // control readback
  cl_pkg::wb_data_t  status_word;                 // counter status readback
  cl_pkg::wb_data_t  wr_ctrl;                     // byte merged write words
  cl_pkg::wb_data_t  wr_tick;
  cl_pkg::wb_data_t  wr_load;
  cl_pkg::wb_data_t  wr_wmark;
  cl_pkg::wb_data_t  rd_next;                     // read word before the flop

  // replace the selected bytes of cur with wdat
  function automatic cl_pkg::wb_data_t merge_bytes(
    input cl_pkg::wb_data_t cur,
    input cl_pkg::wb_data_t wdat,
    input logic [3:0]       sel
  );
    cl_pkg::wb_data_t res;
    res = cur;
    for (int i = 0; i < 4; i++)
    begin
      if (sel[i])
      begin
        res[8*i +: 8] = wdat[8*i +: 8];           // one lane per select bit
      end
    end
    return res;
  endfunction

  // ----------------------------------------
  // bus handshake
  // ----------------------------------------
  assign req    = wb_cyc && wb_stb && (state == cl_pkg::wb_idle);  // ignored while ack shows
  assign wr_req = req && wb_we;
  assign wb_ack = (state == cl_pkg::wb_ack);      // exactly one cycle per access

  // ----------------------------------------
  // readback words
  // ----------------------------------------
  always_comb
  begin
    ctrl_word                       = '0;
    ctrl_word[cl_pkg::ctrl_enable]  = enable;
    ctrl_word[cl_pkg::ctrl_oneshot] = oneshot;   // clear and load read as zero

    status_word                           = '0;
    status_word[cnt_lsb +: count_width]   = cnt;
    status_word[tick_cnt_lsb +: tick_width] = tick_cnt;
    status_word[tick_bit]                 = tick;
    status_word[ge_bit]                   = ge_watermark;
  end

  // writes land on the current value so unselected bytes keep it
  assign wr_ctrl  = merge_bytes(ctrl_word, wb_dat_w, wb_sel);
  assign wr_tick  = merge_bytes(cl_pkg::wb_data_t'(tick_value), wb_dat_w, wb_sel);
  assign wr_load  = merge_bytes(cl_pkg::wb_data_t'(load_value), wb_dat_w, wb_sel);
  assign wr_wmark = merge_bytes(cl_pkg::wb_data_t'(watermark), wb_dat_w, wb_sel);

  // read mux with zero for unmapped offsets
  always_comb
  begin
    case (wb_adr)
      cl_pkg::reg_id0:        rd_next = cl_pkg::cl_id0;
      cl_pkg::reg_id1:        rd_next = cl_pkg::cl_id1;
      cl_pkg::reg_version:    rd_next = cl_pkg::cl_version;
      cl_pkg::reg_ctrl:       rd_next = ctrl_word;
      cl_pkg::reg_tick_value: rd_next = cl_pkg::wb_data_t'(tick_value);
      cl_pkg::reg_load_value: rd_next = cl_pkg::wb_data_t'(load_value);
      cl_pkg::reg_watermark:  rd_next = cl_pkg::wb_data_t'(watermark);
      cl_pkg::reg_count:      rd_next = status_word;
      default:                rd_next = '0;
    endcase
  end

  // ----------------------------------------
  // fsm and control registers
  // ----------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      state      <= cl_pkg::wb_idle;
      enable     <= 1'b0;
      oneshot    <= 1'b0;
      clear      <= 1'b0;
      load       <= 1'b0;
      tick_value <= '0;
      load_value <= '0;
      watermark  <= '0;
    end
    else
    begin
      clear <= 1'b0;                              // pulses drop after one cycle
      load  <= 1'b0;

      case (state)
        cl_pkg::wb_idle:
        begin
          if (req)
          begin
            state <= cl_pkg::wb_ack;
          end
        end
        default:
        begin
          state <= cl_pkg::wb_idle;               // ack always ends here
        end
      endcase

      if (wr_req)
      begin
        case (wb_adr)
          cl_pkg::reg_ctrl:
          begin
            enable  <= wr_ctrl[cl_pkg::ctrl_enable];
            oneshot <= wr_ctrl[cl_pkg::ctrl_oneshot];
            clear   <= wr_ctrl[cl_pkg::ctrl_clear];
            load    <= wr_ctrl[cl_pkg::ctrl_load];
          end
          cl_pkg::reg_tick_value: tick_value <= wr_tick[tick_width-1:0];
          cl_pkg::reg_load_value: load_value <= wr_load[count_width-1:0];
          cl_pkg::reg_watermark:  watermark  <= wr_wmark[count_width-1:0];
          default:                ;           // read only or unmapped
        endcase
      end
    end
  end

  // read data is captured with the request and shown with ack
  always_ff @(posedge clk_main_a0)
  begin
    if (req)
    begin
      wb_dat_r <= rd_next;
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_ack_one_cycle : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n)
    wb_ack |=> !wb_ack
  );

  // seen from the bus pins only
  a_ack_after_req : assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb)
  );

endmodule

`default_nettype wire

// File: src/cl_pkg.sv
`default_nettype none

package cl_pkg;

  // ----------------------------------------
  // bus types
  // ----------------------------------------
  typedef logic [31:0] wb_data_t;                 // wishbone data word
  typedef logic [7:0]  wb_addr_t;                 // byte address inside the window

  // ----------------------------------------
  // register map
  // ----------------------------------------
  localparam wb_addr_t reg_id0        = 8'h00;    // read only
  localparam wb_addr_t reg_id1        = 8'h04;    // read only
  localparam wb_addr_t reg_version    = 8'h08;    // read only
  localparam wb_addr_t reg_ctrl       = 8'h0C;    // enable oneshot clear load
  localparam wb_addr_t reg_tick_value = 8'h10;    // prescaler period
  localparam wb_addr_t reg_load_value = 8'h14;    // value taken on load
  localparam wb_addr_t reg_watermark  = 8'h18;    // compare level for cnt
  localparam wb_addr_t reg_count      = 8'h1C;    // read only counter status

  // control word bit positions
  localparam int ctrl_enable  = 0;                // count while set
  localparam int ctrl_oneshot = 1;                // saturate instead of wrap
  localparam int ctrl_clear   = 2;                // self clearing
  localparam int ctrl_load    = 3;                // self clearing

  // ----------------------------------------
  // identification
  // ----------------------------------------
  localparam wb_data_t cl_id0     = 32'hF000_1D0F;  // device and vendor
  localparam wb_data_t cl_id1     = 32'h1D51_FEDC;  // subsystem ids
  localparam wb_data_t cl_version = 32'hEEEE_EE00;  // build version

  // bus slave states
  typedef enum logic
  {
    wb_idle,                                      // waiting for cyc and stb
    wb_ack                                        // ack showing this cycle
  } wb_state_t;

  // default widths that the top level passes down
  localparam int tick_width_default  = 8;
  localparam int count_width_default = 16;

endpackage

`default_nettype wire
